// File: rtl/rms_norm_settings.svh
// ------------------------------
// Lane count, vector limits, widths and
// the inverse square root constant
// ------------------------------
`ifndef RMS_NORM_SETTINGS_SVH
`define RMS_NORM_SETTINGS_SVH

// Elements per beat and vector limits
`define RMS_LANES 4
`define RMS_MAX_LEN 64
`define RMS_SLOTS (`RMS_MAX_LEN / `RMS_LANES)

// Datapath widths
`define RMS_LEN_WIDTH 7
`define RMS_ACC_WIDTH 21
`define RMS_SCALE_WIDTH 5
`define RMS_LOG2K_WIDTH 3

// Bit-level inverse square root seed for bfloat16
`define RMS_ISQRT_MAGIC 16'h5F37

`endif

// File: rtl/rms_norm_pkg.sv
// ------------------------------
// bfloat16 word type and the integer to
// bfloat16 conversion
// ------------------------------
`include "rms_norm_settings.svh"

package rms_norm_pkg;

  typedef struct packed {
    logic       sign;
    logic [7:0] exp;
    logic [6:0] man;
  } bf16_fields_t;

  // Raw word for the inverse square root, fields for everything else
  typedef union packed {
    logic [15:0]  bits;
    bf16_fields_t f;
  } bf16_t;

  // Sign/magnitude integer to bfloat16, bias 127, mantissa truncated
  function automatic bf16_t int_to_bf16(input logic sign,
                                        input logic [`RMS_ACC_WIDTH-1:0] mag);
    bf16_t                     r;
    logic [`RMS_ACC_WIDTH-1:0] norm;
    int                        msb;
    r   = '0;
    msb = 0;
    for (int i = 0; i < `RMS_ACC_WIDTH; i++) begin
      if (mag[i]) begin
        msb = i;
      end
    end
    if (mag != '0) begin
      // Leading one moves to the top bit, then drops out as hidden bit
      norm     = mag << (`RMS_ACC_WIDTH - 1 - msb);
      r.f.sign = sign;
      r.f.exp  = 8'(127 + msb);
      r.f.man  = norm[`RMS_ACC_WIDTH-2 -: 7];
    end
    return r;
  endfunction

endpackage

// File: rtl/rms_norm_ctrl.sv
// ------------------------------
// Phase FSM, configuration registers,
// beat counting and buffer read issue
// ------------------------------
`include "rms_norm_settings.svh"

module rms_norm_ctrl (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               cfg_valid,
  output logic                               cfg_ready,
  input  logic [`RMS_LEN_WIDTH-1:0]          cfg_length,
  input  logic [`RMS_LOG2K_WIDTH-1:0]        cfg_log2_k,
  input  logic signed [`RMS_SCALE_WIDTH-1:0] cfg_in_scale,
  input  logic signed [`RMS_SCALE_WIDTH-1:0] cfg_out_scale,
  input  logic                               in_valid,
  output logic                               in_ready,
  input  logic                               inv_valid,
  input  logic                               lane_last,
  output logic                               beat_accept,
  output logic                               load_done,
  output logic                               acc_clear,
  output logic                               rd_en,
  output logic                               rd_last,
  output logic [`RMS_LOG2K_WIDTH-1:0]        log2_k,
  output logic signed [`RMS_SCALE_WIDTH-1:0] in_scale,
  output logic signed [`RMS_SCALE_WIDTH-1:0] out_scale
);

  localparam logic [1:0] IDLE   = 2'd0;
  localparam logic [1:0] LOAD   = 2'd1;
  localparam logic [1:0] REDUCE = 2'd2;
  localparam logic [1:0] NORM   = 2'd3;

  logic [1:0]                phase;
  logic [`RMS_LEN_WIDTH-1:0] length_q;
  logic [`RMS_LEN_WIDTH-1:0] last_beat;
  logic [`RMS_LEN_WIDTH-1:0] beat_cnt;
  logic [`RMS_LEN_WIDTH-1:0] rd_cnt;
  logic                      cfg_fire;

  assign cfg_ready   = (phase == IDLE);
  assign in_ready    = (phase == LOAD);
  assign cfg_fire    = cfg_valid && cfg_ready;
  assign acc_clear   = cfg_fire;
  assign beat_accept = in_valid && in_ready;

  // Index of the final beat of the vector
  assign last_beat = (length_q >> $clog2(`RMS_LANES)) - 1'b1;
  assign load_done = beat_accept && (beat_cnt == last_beat);
  assign rd_last   = rd_en && (rd_cnt == last_beat);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase     <= IDLE;
      length_q  <= '0;
      log2_k    <= '0;
      in_scale  <= '0;
      out_scale <= '0;
      beat_cnt  <= '0;
      rd_cnt    <= '0;
      rd_en     <= 1'b0;
    end else begin
      case (phase)
        IDLE: begin
          if (cfg_fire) begin
            length_q  <= cfg_length;
            log2_k    <= cfg_log2_k;
            in_scale  <= cfg_in_scale;
            out_scale <= cfg_out_scale;
            beat_cnt  <= '0;
            phase     <= LOAD;
          end
        end
        LOAD: begin
          if (beat_accept) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (load_done) begin
              phase <= REDUCE;
            end
          end
        end
        REDUCE: begin
          // Reads start once the inverse RMS is known
          if (inv_valid) begin
            rd_en  <= 1'b1;
            rd_cnt <= '0;
            phase  <= NORM;
          end
        end
        default: begin
          if (rd_en) begin
            rd_cnt <= rd_cnt + 1'b1;
          end
          if (rd_last) begin
            rd_en <= 1'b0;
          end
          if (lane_last) begin
            phase <= IDLE;
          end
        end
      endcase
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  a_cfg_length: assert property (@(posedge clk) disable iff (!rst_n)
    cfg_fire |-> cfg_length != '0 && (cfg_length % `RMS_LANES) == 0
                 && cfg_length <= `RMS_MAX_LEN);

  // Beats are taken only while the vector still owes them
  a_beat_in_load: assert property (@(posedge clk) disable iff (!rst_n)
    beat_accept |-> beat_cnt <= last_beat);

endmodule

// File: rtl/square_accum.sv
// ------------------------------
// Lane squaring and square sum
// ------------------------------
`include "rms_norm_settings.svh"

module square_accum (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [`RMS_LANES-1:0][7:0]     in_data,
  input  logic                           beat_accept,
  input  logic                           acc_clear,
  input  logic                           load_done,
  output logic [`RMS_ACC_WIDTH-1:0]      sum,
  output logic                           sum_valid
);

  // (-128)^2 needs 15 bits unsigned
  logic [`RMS_LANES-1:0][14:0] sq;
  logic                        sq_valid;
  logic                        sq_last;
  logic [`RMS_ACC_WIDTH-1:0]   beat_total;

  always_ff @(posedge clk) begin
    for (int i = 0; i < `RMS_LANES; i++) begin
      sq[i] <= 15'($signed(in_data[i]) * $signed(in_data[i]));
    end
  end

  always_comb begin
    beat_total = '0;
    for (int i = 0; i < `RMS_LANES; i++) begin
      beat_total = beat_total + `RMS_ACC_WIDTH'(sq[i]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sq_valid  <= 1'b0;
      sq_last   <= 1'b0;
      sum       <= '0;
      sum_valid <= 1'b0;
    end else begin
      sq_valid  <= beat_accept;
      sq_last   <= load_done;
      sum_valid <= sq_last;
      if (acc_clear) begin
        sum <= '0;
      end else if (sq_valid) begin
        sum <= sum + beat_total;
      end
    end
  end

  a_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
    sq_valid && !acc_clear |=> sum >= $past(sum));

endmodule

// File: rtl/vector_buffer.sv
// ------------------------------
// Input byte and gamma slot storage
// ------------------------------
`include "rms_norm_settings.svh"

module vector_buffer (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  wr_en,
  input  logic [`RMS_LANES-1:0][7:0]            in_data,
  input  rms_norm_pkg::bf16_t [`RMS_LANES-1:0]  in_gamma,
  input  logic                                  rd_en,
  input  logic                                  acc_clear,
  output logic [`RMS_LANES-1:0][7:0]            rd_data,
  output rms_norm_pkg::bf16_t [`RMS_LANES-1:0]  rd_gamma
);

  import rms_norm_pkg::*;

  // One extra pointer bit so a full buffer is visible
  localparam int PTR_W = $clog2(`RMS_SLOTS) + 1;
  localparam logic [PTR_W-1:0] FULL = PTR_W'(`RMS_SLOTS);

  logic [`RMS_LANES-1:0][7:0] data_mem [`RMS_SLOTS];
  bf16_t [`RMS_LANES-1:0]     gamma_mem [`RMS_SLOTS];
  logic [PTR_W-1:0]           wr_ptr;
  logic [PTR_W-1:0]           rd_ptr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (acc_clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Slot storage and registered read port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      data_mem[wr_ptr[PTR_W-2:0]]  <= in_data;
      gamma_mem[wr_ptr[PTR_W-2:0]] <= in_gamma;
    end
    if (rd_en) begin
      rd_data  <= data_mem[rd_ptr[PTR_W-2:0]];
      rd_gamma <= gamma_mem[rd_ptr[PTR_W-2:0]];
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> wr_ptr != FULL);

endmodule

// File: rtl/inv_rms_unit.sv
// ------------------------------
// Square sum to inverse RMS
// ------------------------------
`include "rms_norm_settings.svh"

module inv_rms_unit (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [`RMS_ACC_WIDTH-1:0]          sum,
  input  logic                               sum_valid,
  input  logic signed [`RMS_SCALE_WIDTH-1:0] in_scale,
  input  logic [`RMS_LOG2K_WIDTH-1:0]        log2_k,
  output rms_norm_pkg::bf16_t                inv_rms,
  output logic                               inv_valid
);

  import rms_norm_pkg::*;

  bf16_t sum_bf;
  bf16_t mean_bf;
  bf16_t isqrt;

  always_comb begin
    sum_bf  = int_to_bf16(1'b0, sum);
    mean_bf = sum_bf;
    // Squares carry the input scale twice, K is a power of two
    mean_bf.f.exp = sum_bf.f.exp - (8'(in_scale) << 1) - 8'(log2_k);
    // Magic-constant estimate, no refinement step
    isqrt.bits = `RMS_ISQRT_MAGIC - (mean_bf.bits >> 1);
    if (sum_bf.bits == '0) begin
      isqrt = '0;
    end
  end

  // Held for the whole NORM phase
  always_ff @(posedge clk) begin
    if (sum_valid) begin
      inv_rms <= isqrt;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inv_valid <= 1'b0;
    end else begin
      inv_valid <= sum_valid;
    end
  end

endmodule

// File: rtl/bf16_mult.sv
// ------------------------------
// Truncating bfloat16 multiplier
// ------------------------------
module bf16_mult (
  input  logic                clk,
  input  logic                rst_n,
  input  rms_norm_pkg::bf16_t a,
  input  rms_norm_pkg::bf16_t b,
  input  logic                valid,
  output rms_norm_pkg::bf16_t z,
  output logic                z_valid
);

  import rms_norm_pkg::*;

  logic [15:0]       prod;
  logic signed [9:0] e_sum;
  bf16_t             z_n;

  always_comb begin
    // Significand product is 1.x * 1.x, so the top bit says normalize
    prod  = {1'b1, a.f.man} * {1'b1, b.f.man};
    e_sum = 10'(a.f.exp) + 10'(b.f.exp) - 10'd127 + 10'(prod[15]);
    z_n.f.sign = a.f.sign ^ b.f.sign;
    z_n.f.exp  = e_sum[7:0];
    z_n.f.man  = prod[15] ? prod[14:8] : prod[13:7];
    // Zero operands and underflow flush to zero
    if (a.f.exp == '0 || b.f.exp == '0 || e_sum <= 0) begin
      z_n = '0;
    end else if (e_sum > 254) begin
      z_n.f.exp = 8'd254;
      z_n.f.man = 7'h7F;
    end
  end

  always_ff @(posedge clk) begin
    z <= z_n;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      z_valid <= 1'b0;
    end else begin
      z_valid <= valid;
    end
  end

endmodule

// File: rtl/norm_lane.sv
// ------------------------------
// One output lane: int8 to bfloat16,
// two products, back to saturated int8
// ------------------------------
`include "rms_norm_settings.svh"

module norm_lane (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               rd_en,
  input  logic                               rd_last,
  input  logic [7:0]                         rd_data,
  input  rms_norm_pkg::bf16_t                rd_gamma,
  input  rms_norm_pkg::bf16_t                inv_rms,
  input  logic signed [`RMS_SCALE_WIDTH-1:0] in_scale,
  input  logic signed [`RMS_SCALE_WIDTH-1:0] out_scale,
  output logic                               out_valid,
  output logic [7:0]                         out_data,
  output logic                               out_last
);

  import rms_norm_pkg::*;

  logic       v0, v1, v2, v3;
  logic       last0, last1, last2, last3;
  logic [7:0] mag8;
  bf16_t      x_conv, x_bf, g_q, xg, xn;
  int         e;
  logic [9:0] half;
  logic [8:0] rnd;
  logic [7:0] sat;

  // Byte to bfloat16 with the input scale as exponent offset
  always_comb begin
    mag8   = rd_data[7] ? 8'(-rd_data) : rd_data;
    x_conv = int_to_bf16(rd_data[7], `RMS_ACC_WIDTH'(mag8));
    if (x_conv.bits != '0) begin
      x_conv.f.exp = x_conv.f.exp - 8'(in_scale);
    end
  end

  always_ff @(posedge clk) begin
    x_bf <= x_conv;
    g_q  <= rd_gamma;
  end

  bf16_mult i_mult_gamma (
    .clk     (clk),
    .rst_n   (rst_n),
    .a       (x_bf),
    .b       (g_q),
    .valid   (v1),
    .z       (xg),
    .z_valid (v2)
  );

  bf16_mult i_mult_rms (
    .clk     (clk),
    .rst_n   (rst_n),
    .a       (xg),
    .b       (inv_rms),
    .valid   (v2),
    .z       (xn),
    .z_valid (v3)
  );

  // ------------------------------
  // Back to int8
  // ------------------------------
  always_comb begin
    e = int'(xn.f.exp) + int'(out_scale);
    // half holds twice the magnitude, so bit 0 is the half bit
    if (xn.bits == '0 || e < 126) begin
      half = '0;
    end else if (e > 134) begin
      half = 10'h3FE;
    end else if (e >= 133) begin
      half = 10'({1'b1, xn.f.man}) << (e - 133);
    end else begin
      half = 10'({1'b1, xn.f.man}) >> (133 - e);
    end
    rnd = 9'((half + 10'd1) >> 1);
    if (!xn.f.sign) begin
      sat = (rnd > 9'd127) ? 8'h7F : 8'(rnd);
    end else begin
      sat = (rnd > 9'd128) ? 8'h80 : 8'(-rnd);
    end
  end

  always_ff @(posedge clk) begin
    out_data <= sat;
  end

  // v0 lines up with the buffer's registered read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      v0        <= 1'b0;
      v1        <= 1'b0;
      last0     <= 1'b0;
      last1     <= 1'b0;
      last2     <= 1'b0;
      last3     <= 1'b0;
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else begin
      v0        <= rd_en;
      v1        <= v0;
      last0     <= rd_last;
      last1     <= last0;
      last2     <= last1;
      last3     <= last2;
      out_valid <= v3;
      out_last  <= v3 && last3;
    end
  end

endmodule

// File: rtl/rms_norm.sv
// ------------------------------
// RMS norm top level
// ------------------------------
`include "rms_norm_settings.svh"

module rms_norm (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 cfg_valid,
  output logic                                 cfg_ready,
  input  logic [`RMS_LEN_WIDTH-1:0]            cfg_length,
  input  logic [`RMS_LOG2K_WIDTH-1:0]          cfg_log2_k,
  input  logic signed [`RMS_SCALE_WIDTH-1:0]   cfg_in_scale,
  input  logic signed [`RMS_SCALE_WIDTH-1:0]   cfg_out_scale,
  input  logic                                 in_valid,
  output logic                                 in_ready,
  input  logic [`RMS_LANES-1:0][7:0]           in_data,
  input  rms_norm_pkg::bf16_t [`RMS_LANES-1:0] in_gamma,
  output logic                                 out_valid,
  output logic [`RMS_LANES-1:0][7:0]           out_data,
  output logic                                 out_last
);

  import rms_norm_pkg::*;

  logic                               beat_accept, load_done, acc_clear;
  logic                               rd_en, rd_last, sum_valid, inv_valid;
  logic [`RMS_LOG2K_WIDTH-1:0]        log2_k;
  logic signed [`RMS_SCALE_WIDTH-1:0] in_scale, out_scale;
  logic [`RMS_ACC_WIDTH-1:0]          sum;
  bf16_t                              inv_rms;
  logic [`RMS_LANES-1:0][7:0]         rd_data;
  bf16_t [`RMS_LANES-1:0]             rd_gamma;
  logic [`RMS_LANES-1:0]              lane_valid, lane_last;

  // All lanes run in lockstep, lane 0 speaks for the beat
  assign out_valid = lane_valid[0];
  assign out_last  = lane_last[0];

  rms_norm_ctrl i_ctrl (
    .clk(clk), .rst_n(rst_n),
    .cfg_valid(cfg_valid), .cfg_ready(cfg_ready), .cfg_length(cfg_length),
    .cfg_log2_k(cfg_log2_k), .cfg_in_scale(cfg_in_scale), .cfg_out_scale(cfg_out_scale),
    .in_valid(in_valid), .in_ready(in_ready), .inv_valid(inv_valid),
    .lane_last(lane_last[0]), .beat_accept(beat_accept), .load_done(load_done),
    .acc_clear(acc_clear), .rd_en(rd_en), .rd_last(rd_last),
    .log2_k(log2_k), .in_scale(in_scale), .out_scale(out_scale)
  );

  square_accum i_accum (
    .clk(clk), .rst_n(rst_n), .in_data(in_data), .beat_accept(beat_accept),
    .acc_clear(acc_clear), .load_done(load_done), .sum(sum), .sum_valid(sum_valid)
  );

  vector_buffer i_buffer (
    .clk(clk), .rst_n(rst_n), .wr_en(beat_accept), .in_data(in_data),
    .in_gamma(in_gamma), .rd_en(rd_en), .acc_clear(acc_clear),
    .rd_data(rd_data), .rd_gamma(rd_gamma)
  );

  inv_rms_unit i_inv_rms (
    .clk(clk), .rst_n(rst_n), .sum(sum), .sum_valid(sum_valid),
    .in_scale(in_scale), .log2_k(log2_k), .inv_rms(inv_rms), .inv_valid(inv_valid)
  );

  for (genvar g = 0; g < `RMS_LANES; g++) begin : g_lane
    norm_lane i_lane (
      .clk(clk), .rst_n(rst_n), .rd_en(rd_en), .rd_last(rd_last),
      .rd_data(rd_data[g]), .rd_gamma(rd_gamma[g]), .inv_rms(inv_rms),
      .in_scale(in_scale), .out_scale(out_scale), .out_valid(lane_valid[g]),
      .out_data(out_data[g]), .out_last(lane_last[g])
    );
  end

endmodule

// File: testbench/tb_rms_norm.sv
// ------------------------------
// File-driven testbench for the RMS norm block
// ------------------------------
`include "rms_norm_settings.svh"

module tb_rms_norm;

  import rms_norm_pkg::*;

  // Last accepted input beat to first output beat, in cycles
  localparam int LATENCY = 9;

  logic                               clk;
  logic                               rst_n;
  logic                               cfg_valid;
  logic                               cfg_ready;
  logic [`RMS_LEN_WIDTH-1:0]          cfg_length;
  logic [`RMS_LOG2K_WIDTH-1:0]        cfg_log2_k;
  logic signed [`RMS_SCALE_WIDTH-1:0] cfg_in_scale;
  logic signed [`RMS_SCALE_WIDTH-1:0] cfg_out_scale;
  logic                               in_valid;
  logic                               in_ready;
  logic [`RMS_LANES-1:0][7:0]         in_data;
  bf16_t [`RMS_LANES-1:0]             in_gamma;
  logic                               out_valid;
  logic [`RMS_LANES-1:0][7:0]         out_data;
  logic                               out_last;

  // Vectors and beats from the data file
  int                       vec_len[$];
  int                       vec_log2_k[$];
  int                       vec_in_scale[$];
  int                       vec_out_scale[$];
  logic [8*`RMS_LANES-1:0]  beat_data[$];
  logic [16*`RMS_LANES-1:0] beat_gamma[$];
  logic [8*`RMS_LANES-1:0]  exp_data[$];
  logic                     exp_last[$];

  integer seed;
  int     errors = 0;
  int     checked = 0;
  int     cycle = 0;
  int     owed = 0;
  int     outs_in_vec = 0;
  int     last_acc_cycle = 0;
  int     last_out_cycle = 0;
  logic   busy = 1'b0;
  logic   last_seen = 1'b0;
  logic   file_read = 1'b0;

  rms_norm i_rms_norm (
    .clk(clk), .rst_n(rst_n),
    .cfg_valid(cfg_valid), .cfg_ready(cfg_ready), .cfg_length(cfg_length),
    .cfg_log2_k(cfg_log2_k), .cfg_in_scale(cfg_in_scale), .cfg_out_scale(cfg_out_scale),
    .in_valid(in_valid), .in_ready(in_ready), .in_data(in_data), .in_gamma(in_gamma),
    .out_valid(out_valid), .out_data(out_data), .out_last(out_last)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // ------------------------------
  // Data file
  // ------------------------------
  task automatic read_tests();
    int    fd;
    int    n;
    int    f[8];
    int    total;
    string line;
    fd = $fopen("testbench/rms_norm_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the test vector file");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 0) begin
        case (line.getc(0))
          "C": begin
            n = $sscanf(line, "C %d %d %d %d", f[0], f[1], f[2], f[3]);
            vec_len.push_back(f[0]);
            vec_log2_k.push_back(f[1]);
            vec_in_scale.push_back(f[2]);
            vec_out_scale.push_back(f[3]);
          end
          "I": begin
            n = $sscanf(line, "I %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
            beat_data.push_back({f[3][7:0], f[2][7:0], f[1][7:0], f[0][7:0]});
            beat_gamma.push_back({f[7][15:0], f[6][15:0], f[5][15:0], f[4][15:0]});
          end
          "E": begin
            n = $sscanf(line, "E %h %h %h %h", f[0], f[1], f[2], f[3]);
            exp_data.push_back({f[3][7:0], f[2][7:0], f[1][7:0], f[0][7:0]});
          end
          default: begin
          end
        endcase
      end
    end
    $fclose(fd);
    // Final beat of each vector carries out_last
    total = 0;
    foreach (vec_len[v]) begin
      for (int b = 0; b < vec_len[v] / `RMS_LANES; b++) begin
        exp_last.push_back(b == vec_len[v] / `RMS_LANES - 1);
      end
      total += vec_len[v] / `RMS_LANES;
    end
    if (beat_data.size() != total || exp_data.size() != total) begin
      $display("Test file beat counts do not match the vector lengths");
      errors++;
    end
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic send_config(input int v);
    logic taken;
    cfg_valid     = 1'b1;
    cfg_length    = `RMS_LEN_WIDTH'(vec_len[v]);
    cfg_log2_k    = `RMS_LOG2K_WIDTH'(vec_log2_k[v]);
    cfg_in_scale  = `RMS_SCALE_WIDTH'(vec_in_scale[v]);
    cfg_out_scale = `RMS_SCALE_WIDTH'(vec_out_scale[v]);
    do begin
      @(negedge clk);
      taken = cfg_ready;
      @(posedge clk);
      #10;
    end while (!taken);
    cfg_valid = 1'b0;
  endtask

  task automatic send_beat(input int k);
    logic taken;
    // Random idle cycles before the beat
    while (($random(seed) & 3) == 0) begin
      in_valid = 1'b0;
      @(posedge clk);
      #10;
    end
    in_valid = 1'b1;
    in_data  = beat_data[k];
    in_gamma = beat_gamma[k];
    do begin
      @(negedge clk);
      taken = in_ready;
      @(posedge clk);
      #10;
    end while (!taken);
    in_valid = 1'b0;
  endtask

  // ------------------------------
  // Output and handshake checks
  // ------------------------------
  task automatic check_beat();
    logic [8*`RMS_LANES-1:0] e;
    logic                    l;
    if (exp_data.size() == 0) begin
      $display("Output beat at %0t arrived with nothing left to expect", $time);
      errors++;
      return;
    end
    e = exp_data.pop_front();
    l = exp_last.pop_front();
    for (int i = 0; i < `RMS_LANES; i++) begin
      if (out_data[i] !== e[8*i +: 8]) begin
        $display("** Error at %0t: out_data[%0d] = %h, expected %h",
                 $time, i, out_data[i], e[8*i +: 8]);
        errors++;
      end
    end
    if (out_last !== l) begin
      $display("** Error at %0t: out_last = %b, expected %b", $time, out_last, l);
      errors++;
    end
    if (outs_in_vec == 0 && cycle - last_acc_cycle != LATENCY) begin
      $display("** Error at %0t: out_valid latency = %0d, expected %0d",
               $time, cycle - last_acc_cycle, LATENCY);
      errors++;
    end
    // Beats of one vector leave on consecutive cycles
    if (outs_in_vec > 0 && cycle - last_out_cycle != 1) begin
      $display("** Error at %0t: out_valid spacing = %0d cycles, expected 1",
               $time, cycle - last_out_cycle);
      errors++;
    end
    last_out_cycle = cycle;
    outs_in_vec++;
    checked++;
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      if (busy && cfg_ready) begin
        $display("cfg_ready went high at %0t while a vector was in flight", $time);
        errors++;
      end
      if (last_seen && !cfg_ready) begin
        $display("cfg_ready did not return after out_last at %0t", $time);
        errors++;
      end
      last_seen = 1'b0;
      if (in_ready && owed == 0) begin
        $display("in_ready high at %0t with no input beats owed", $time);
        errors++;
      end
      if (cfg_valid && cfg_ready) begin
        busy        = 1'b1;
        owed        = int'(cfg_length) / `RMS_LANES;
        outs_in_vec = 0;
      end
      if (in_valid && in_ready && owed > 0) begin
        owed--;
        if (owed == 0) begin
          last_acc_cycle = cycle;
        end
      end
      if (out_valid) begin
        check_beat();
      end
      if (out_last) begin
        busy      = 1'b0;
        last_seen = 1'b1;
      end
    end
  end

  initial begin
    int k;
    seed          = 32'he970;
    rst_n         = 1'b0;
    cfg_valid     = 1'b0;
    cfg_length    = '0;
    cfg_log2_k    = '0;
    cfg_in_scale  = '0;
    cfg_out_scale = '0;
    in_valid      = 1'b0;
    in_data       = '0;
    in_gamma      = '0;
    read_tests();
    file_read = 1'b1;
    repeat (8) @(posedge clk);
    #10;
    rst_n = 1'b1;
    @(negedge clk);
    if (!cfg_ready || in_ready || out_valid || out_last) begin
      $display("Handshake outputs wrong after reset at %0t", $time);
      errors++;
    end
    @(posedge clk);
    #10;
    k = 0;
    foreach (vec_len[v]) begin
      send_config(v);
      for (int b = 0; b < vec_len[v] / `RMS_LANES; b++) begin
        send_beat(k);
        k++;
      end
    end
    wait (exp_data.size() == 0 && !busy);
    repeat (2) @(posedge clk);
    $display("%0d output beats checked, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the number of beats and vectors
  initial begin
    int limit;
    wait (file_read);
    limit = beat_data.size() * 8 + vec_len.size() * 30 + 40;
    repeat (limit) @(posedge clk);
    $display("Timeout, the run did not finish within %0d cycles", limit);
    $display("%0d output beats checked, %0d errors", checked, errors + 1);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: testbench/rms_norm_tests.txt
# C length log2_k in_scale out_scale (decimal)
# I lane0..lane3 bytes then lane0..lane3 gamma words, E lane0..lane3 bytes (hex)
# Gamma one, values in order
C 8 3 0 4
I 01 02 03 FC 3F80 3F80 3F80 3F80
I 05 FA 07 F8 3F80 3F80 3F80 3F80
E 03 07 0A F3
E 10 EC 17 E6
# Large inputs, mixed-sign gamma, saturation
C 4 2 0 1
I 80 7F 40 E0 4280 C280 4300 C280
E 80 80 7F 2C
# All-zero vector
C 8 2 0 0
I 00 00 00 00 3F80 3F80 3F80 3F80
I 00 00 00 00 3F80 3F80 3F80 3F80
E 00 00 00 00
E 00 00 00 00
# Input scale, output scale and K
C 4 1 1 3
I 10 F0 10 F0 3F80 4000 BF00 3FC0
E 06 F5 FD F7
C 4 0 -2 4
I 03 FB 07 01 3F80 3F80 3F80 3F80
E 05 F7 0C 02
# First vector again, back to back
C 8 3 0 4
I 01 02 03 FC 3F80 3F80 3F80 3F80
I 05 FA 07 F8 3F80 3F80 3F80 3F80
E 03 07 0A F3
E 10 EC 17 E6

// File: rms_norm.f
+incdir+rtl
rtl/rms_norm_pkg.sv
rtl/rms_norm_ctrl.sv
rtl/square_accum.sv
rtl/vector_buffer.sv
rtl/inv_rms_unit.sv
rtl/bf16_mult.sv
rtl/norm_lane.sv
rtl/rms_norm.sv
testbench/tb_rms_norm.sv

// File: Makefile
# Verilator build, run and lint for the RMS norm block

VERILATOR  ?= verilator
TOP        ?= tb_rms_norm
RTL_TOP    ?= rms_norm
FILELIST   ?= rms_norm.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_MSG   ?= RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
